/* Makefile */
TOP := adc_rx_tb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f adc_rx.f -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

/* adc_rx.f */
common/adc_rx_pkg.sv
logic/adc_delay_line.sv
logic/adc_threshold_trigger.sv
logic/adc_word_packer.sv
logic/adc_sample_fifo.sv
record_control/adc_record_control.sv
logic/adc_rx_top.sv
bench/adc_rx_properties.sv
bench/adc_rx_tb.sv

/* bench/adc_rx_properties.sv */
// bound assertions on the receiver top: reset state, fifo read discipline, loss flag
`timescale 1ns/1ns

module adc_rx_properties import adc_rx_pkg::*; (
    input logic        ADC_ENC,
    input logic        rst_adc_sync,
    input logic        done,
    input logic        fifo_read,
    input logic        fifo_empty,
    input lost_count_t lost_count,
    input logic        lost_error
);

    // idle and empty once reset has been applied
    a_reset_idle: assert property (@(posedge ADC_ENC)
        rst_adc_sync |=> done && fifo_empty && !lost_error)
        else $error("receiver not idle after reset");

    a_no_empty_read: assert property (@(posedge ADC_ENC) disable iff (rst_adc_sync)
        !(fifo_read && fifo_empty))
        else $error("fifo_read applied to an empty fifo");

    a_lost_flag: assert property (@(posedge ADC_ENC) disable iff (rst_adc_sync)
        lost_error == (lost_count != '0))
        else $error("lost_error disagrees with lost_count");

endmodule

bind adc_rx_top adc_rx_properties u_properties (
    .ADC_ENC      (ADC_ENC),
    .rst_adc_sync (rst_adc_sync),
    .done         (done),
    .fifo_read    (fifo_read),
    .fifo_empty   (fifo_empty),
    .lost_count   (lost_count),
    .lost_error   (lost_error)
);

/* bench/adc_rx_tb.sv */
// adc receiver testbench with clock, reset, ramp stimulus, directed tests and watchdog
`timescale 1ns/1ns

module adc_rx_tb import adc_rx_pkg::*; ();

    localparam int         CLK_PERIOD = 40;
    localparam logic [1:0] ADC_ID     = 2'd2;
    localparam logic [0:0] HEADER_ID  = 1'b1;
    localparam int         FIFO_DEPTH = 16;
    localparam int         REC_LEN    = 12;
    localparam int         LOST_WORDS = 8;
    localparam int         NUM_RUNS   = 9;
    // upper bound on the cycles of one run including setup, record and a two-cycle drain per word
    localparam int         RUN_CYCLES = REC_LEN + 3 * FIFO_DEPTH + 40;
    localparam int         TIMEOUT_NS = 2 * NUM_RUNS * RUN_CYCLES * CLK_PERIOD;

    logic          ADC_ENC;
    logic          rst_adc_sync;
    adc_sample_t   adc_in;
    logic          adc_sync;
    logic          adc_trigger;
    logic          start;
    logic          fifo_read;
    logic          cfg_start_with_sync;
    logic          cfg_ext_trigger_en;
    logic          cfg_single_data;
    rec_count_t    cfg_data_cnt;
    sample_delay_t cfg_sample_dly;
    trig_mode_t    cfg_trig_mode;
    adc_sample_t   cfg_trig_threshold;
    fifo_word_t    fifo_data;
    logic          fifo_empty;
    lost_count_t   lost_count;
    logic          lost_error;
    logic          done;

    fifo_word_t    words[$];  // words popped by the last drain
    integer        seed;
    logic          ramp_down;

    adc_rx_top #(
        .ADC_ID     (ADC_ID),
        .HEADER_ID  (HEADER_ID),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .ADC_ENC             (ADC_ENC),
        .rst_adc_sync        (rst_adc_sync),
        .adc_in              (adc_in),
        .adc_sync            (adc_sync),
        .adc_trigger         (adc_trigger),
        .start               (start),
        .fifo_read           (fifo_read),
        .cfg_start_with_sync (cfg_start_with_sync),
        .cfg_ext_trigger_en  (cfg_ext_trigger_en),
        .cfg_single_data     (cfg_single_data),
        .cfg_data_cnt        (cfg_data_cnt),
        .cfg_sample_dly      (cfg_sample_dly),
        .cfg_trig_mode       (cfg_trig_mode),
        .cfg_trig_threshold  (cfg_trig_threshold),
        .fifo_data           (fifo_data),
        .fifo_empty          (fifo_empty),
        .lost_count          (lost_count),
        .lost_error          (lost_error),
        .done                (done)
    );

    initial begin
        ADC_ENC = 1'b0;
        forever #(CLK_PERIOD / 2) ADC_ENC = ~ADC_ENC;
    end

    // adc ramp stepping once per cycle
    initial begin
        seed   = 74;
        adc_in = adc_sample_t'($random(seed)) & 14'h0fff; // low start leaves room to climb
        forever begin
            @(posedge ADC_ENC);
            adc_in <= ramp_down ? adc_in - 14'd1 : adc_in + 14'd1;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired at %0t, a test did not complete", $time);
        $display("TEST FAILED");
        $fatal(1, "watchdog timeout");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic check_word(input fifo_word_t got, input fifo_word_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0t: %s, got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_count(input lost_count_t got, input lost_count_t exp,
                               input string what);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0t: %s, got %0d expected %0d",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0t: %s, got %b expected %b",
                               $time, what, got, exp));
        end
    endtask

    // header, id, flag, older sample, newer sample
    function automatic fifo_word_t expected_word(input logic flag, input adc_sample_t older,
                                                 input adc_sample_t newer);
        return {HEADER_ID, ADC_ID, flag, older, newer};
    endfunction

    task automatic apply_reset();
        @(posedge ADC_ENC);
        rst_adc_sync <= 1'b1;
        repeat (3) @(posedge ADC_ENC);
        rst_adc_sync <= 1'b0;
    endtask

    task automatic configure(input logic single, input sample_delay_t dly, input logic ext_en,
                             input logic sync_start, input rec_count_t cnt);
        @(posedge ADC_ENC);
        cfg_single_data     <= single;
        cfg_sample_dly      <= dly;
        cfg_ext_trigger_en  <= ext_en;
        cfg_start_with_sync <= sync_start;
        cfg_data_cnt        <= cnt;
        cfg_trig_mode       <= trig_off;
        cfg_trig_threshold  <= '0;
        repeat (8) @(posedge ADC_ENC); // delay line history refills after reset
    endtask

    // first_val is the sample of the first recording cycle
    task automatic pulse_start(output adc_sample_t first_val);
        @(posedge ADC_ENC);
        start <= 1'b1;
        @(posedge ADC_ENC);
        start <= 1'b0;
        @(negedge ADC_ENC);
        first_val = adc_in;
    endtask

    task automatic pulse_trigger(output adc_sample_t first_val);
        @(posedge ADC_ENC);
        adc_trigger <= 1'b1;
        @(posedge ADC_ENC);
        adc_trigger <= 1'b0;
        @(negedge ADC_ENC);
        first_val = adc_in;
    endtask

    task automatic pulse_sync(output adc_sample_t pulse_val, output adc_sample_t next_val);
        @(posedge ADC_ENC);
        adc_sync <= 1'b1;
        @(negedge ADC_ENC);
        pulse_val = adc_in; // input during the sync cycle
        @(posedge ADC_ENC);
        adc_sync <= 1'b0;
        @(negedge ADC_ENC);
        next_val = adc_in;
    endtask

    task automatic wait_record_end();
        @(negedge ADC_ENC);
        while (!done) @(negedge ADC_ENC);
        repeat (3) @(negedge ADC_ENC); // packer and fifo stages
    endtask

    task automatic drain_fifo();
        words.delete();
        @(negedge ADC_ENC);
        while (!fifo_empty) begin
            words.push_back(fifo_data);
            @(posedge ADC_ENC);
            fifo_read <= 1'b1;
            @(posedge ADC_ENC);
            fifo_read <= 1'b0;
            @(negedge ADC_ENC);
        end
    endtask

    // single mode words on a rising ramp with a flag only on the first
    task automatic check_ramp_words(input int n, input adc_sample_t first, input logic flag0);
        fifo_word_t exp;
        check_count(lost_count_t'(words.size()), lost_count_t'(n), "word count");
        for (int i = 0; i < n; i++) begin
            exp = expected_word((i == 0) ? flag0 : 1'b0, '0, first + adc_sample_t'(i));
            check_word(words[i], exp, $sformatf("single mode word %0d", i));
        end
    endtask

    task automatic test_single_record();
        adc_sample_t first;
        apply_reset();
        configure(1'b1, 8'd0, 1'b0, 1'b0, rec_count_t'(REC_LEN));
        pulse_start(first);
        check_flag(done, 1'b0, "done during single record");
        wait_record_end();
        drain_fifo();
        check_ramp_words(REC_LEN, first, 1'b0);
    endtask

    task automatic test_double_record();
        adc_sample_t first;
        fifo_word_t  exp;
        apply_reset();
        configure(1'b0, 8'd0, 1'b0, 1'b0, rec_count_t'(REC_LEN));
        pulse_start(first);
        wait_record_end();
        drain_fifo();
        check_count(lost_count_t'(words.size()), lost_count_t'(REC_LEN / 2), "pair count");
        for (int j = 0; j < REC_LEN / 2; j++) begin
            exp = expected_word(1'b0, first + adc_sample_t'(2 * j),
                                first + adc_sample_t'(2 * j + 1));
            check_word(words[j], exp, $sformatf("double mode word %0d", j));
        end
    endtask

    task automatic test_sync_delay(input sample_delay_t dly);
        adc_sample_t first;
        adc_sample_t pulse_val;
        adc_sample_t next_val;
        fifo_word_t  exp;
        int          flagged;
        int          hit_idx;
        apply_reset();
        configure(1'b1, dly, 1'b0, 1'b0, rec_count_t'(REC_LEN));
        pulse_start(first);
        repeat (2) @(posedge ADC_ENC);
        pulse_sync(pulse_val, next_val);
        wait_record_end();
        drain_fifo();
        check_count(lost_count_t'(words.size()), lost_count_t'(REC_LEN), "delay word count");
        flagged = 0;
        hit_idx = 0;
        foreach (words[i]) begin
            if (words[i][28]) begin
                flagged++;
                hit_idx = i;
            end
        end
        check_count(lost_count_t'(flagged), 8'd1, "words carrying the sync flag");
        // sync marks the sample taken dly cycles earlier
        exp = expected_word(1'b1, '0, pulse_val - adc_sample_t'(dly));
        check_word(words[hit_idx], exp, $sformatf("sync word at delay %0d", dly));
    endtask

    task automatic test_sync_arm_and_trigger();
        adc_sample_t first;
        adc_sample_t pulse_val;
        apply_reset();
        configure(1'b1, 8'd0, 1'b0, 1'b1, rec_count_t'(REC_LEN));
        pulse_start(first); // arms only
        repeat (6) @(negedge ADC_ENC);
        check_flag(done, 1'b0, "done while armed for sync");
        check_flag(fifo_empty, 1'b1, "fifo empty while armed");
        pulse_sync(pulse_val, first);
        wait_record_end();
        drain_fifo();
        check_ramp_words(REC_LEN, first, 1'b0);

        apply_reset();
        configure(1'b1, 8'd0, 1'b1, 1'b0, rec_count_t'(REC_LEN));
        pulse_trigger(first);
        wait_record_end();
        drain_fifo();
        check_ramp_words(REC_LEN, first, 1'b1);
    endtask

    task automatic test_threshold(input trig_mode_t mode);
        adc_sample_t now_val;
        adc_sample_t thr;
        adc_sample_t exp_sample;
        fifo_word_t  exp;
        apply_reset();
        configure(1'b1, 8'd0, 1'b0, 1'b0, rec_count_t'(REC_LEN));
        @(posedge ADC_ENC);
        ramp_down <= (mode == trig_below);
        @(negedge ADC_ENC);
        now_val = adc_in;
        if (mode == trig_above) begin
            thr = now_val + 14'd10;
        end else begin
            thr = now_val - 14'd10;
        end
        @(posedge ADC_ENC);
        cfg_trig_threshold <= thr;
        cfg_trig_mode      <= mode;
        @(negedge ADC_ENC);
        while (done) @(negedge ADC_ENC);
        @(posedge ADC_ENC);
        cfg_trig_mode <= trig_off; // stop a second record while the comparison still holds
        wait_record_end();
        drain_fifo();
        check_count(lost_count_t'(words.size()), lost_count_t'(REC_LEN), "threshold word count");
        // hit registers at the end of the first passing sample so the first word holds the next
        exp_sample = (mode == trig_above) ? thr + 14'd2 : thr - 14'd2;
        exp = expected_word(1'b1, '0, exp_sample);
        check_word(words[0], exp, "first word after the threshold");
        @(posedge ADC_ENC);
        ramp_down <= 1'b0;
    endtask

    task automatic test_overflow();
        adc_sample_t first;
        apply_reset();
        configure(1'b1, 8'd0, 1'b0, 1'b0, '0);
        pulse_start(first);
        @(negedge ADC_ENC);
        while (fifo_empty) @(negedge ADC_ENC);
        check_flag(lost_error, 1'b0, "lost error before the fifo filled");
        // bound the endless record to depth plus the lost words
        @(posedge ADC_ENC);
        cfg_data_cnt <= rec_count_t'(FIFO_DEPTH + LOST_WORDS);
        wait_record_end();
        check_count(lost_count, lost_count_t'(LOST_WORDS), "lost word count");
        check_flag(lost_error, 1'b1, "lost error flag");
        drain_fifo();
        check_ramp_words(FIFO_DEPTH, first, 1'b0);
    endtask

    initial begin
        rst_adc_sync        = 1'b1;
        start               = 1'b0;
        adc_sync            = 1'b0;
        adc_trigger         = 1'b0;
        fifo_read           = 1'b0;
        ramp_down           = 1'b0;
        cfg_start_with_sync = 1'b0;
        cfg_ext_trigger_en  = 1'b0;
        cfg_single_data     = 1'b1;
        cfg_data_cnt        = '0;
        cfg_sample_dly      = '0;
        cfg_trig_mode       = trig_off;
        cfg_trig_threshold  = '0;
        test_single_record();
        test_double_record();
        test_sync_delay(8'd0);
        test_sync_delay(8'd5);
        test_sync_arm_and_trigger();
        test_threshold(trig_above);
        test_threshold(trig_below);
        test_overflow();
        $display("TEST OK");
        $finish;
    end

endmodule

/* common/adc_rx_pkg.sv */
// shared types for the adc receiver: sample, word, count and delay widths, trigger modes
package adc_rx_pkg;

    // one conversion from the 14-bit adc
    typedef logic [13:0] adc_sample_t;

    // packed output word as it sits in the fifo
    typedef logic [31:0] fifo_word_t;

    // record length setting and the running sample count
    typedef logic [23:0] rec_count_t;

    // delay line setting, in ADC_ENC cycles
    typedef logic [7:0] sample_delay_t;

    // saturating count of words dropped on a full fifo
    typedef logic [7:0] lost_count_t;

    // threshold trigger selection
    typedef enum logic [1:0] {
        trig_off   = 2'd0, // threshold trigger disabled
        trig_below = 2'd1, // sample under threshold
        trig_above = 2'd2, // sample over threshold
        trig_drop  = 2'd3  // fall between two samples exceeds threshold
    } trig_mode_t;

endpackage

/* logic/adc_delay_line.sv */
// programmable sample delay of 0 to 255 cycles on a 256-entry memory
`timescale 1ns/1ns

module adc_delay_line import adc_rx_pkg::*; (
    input  logic          ADC_ENC,
    input  logic          rst_adc_sync,
    input  adc_sample_t   adc_in,
    input  sample_delay_t cfg_sample_dly,
    output adc_sample_t   sample_dly
);

    adc_sample_t dly_mem [256];
    logic [7:0]  wr_ptr;
    logic [7:0]  rd_addr;
    adc_sample_t rd_q;

    // free running write pointer
    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            wr_ptr <= 8'd0;
        end else begin
            wr_ptr <= wr_ptr + 8'd1;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        dly_mem[wr_ptr] <= adc_in;
    end

    // the read is registered, so look one entry ahead to keep the delay exact
    assign rd_addr = wr_ptr - cfg_sample_dly + 8'd1;

    always_ff @(posedge ADC_ENC) begin
        if (cfg_sample_dly == 8'd1) begin
            rd_q <= adc_in; // entry is written on this very edge
        end else begin
            rd_q <= dly_mem[rd_addr];
        end
    end

    // delay zero skips the memory altogether
    assign sample_dly = (cfg_sample_dly == 8'd0) ? adc_in : rd_q;

endmodule

/* logic/adc_rx_top.sv */
// adc receiver top: delay line, threshold trigger, record control, packer and fifo
`timescale 1ns/1ns

module adc_rx_top import adc_rx_pkg::*; #(
    parameter logic [1:0] ADC_ID     = 2'd0,
    parameter logic [0:0] HEADER_ID  = 1'b0,
    parameter int         FIFO_DEPTH = 64
) (
    input  logic          ADC_ENC,
    input  logic          rst_adc_sync,
    input  adc_sample_t   adc_in,
    input  logic          adc_sync,
    input  logic          adc_trigger,
    input  logic          start,
    input  logic          fifo_read,
    input  logic          cfg_start_with_sync,
    input  logic          cfg_ext_trigger_en,
    input  logic          cfg_single_data,
    input  rec_count_t    cfg_data_cnt,
    input  sample_delay_t cfg_sample_dly,
    input  trig_mode_t    cfg_trig_mode,
    input  adc_sample_t   cfg_trig_threshold,
    output fifo_word_t    fifo_data,
    output logic          fifo_empty,
    output lost_count_t   lost_count,
    output logic          lost_error,
    output logic          done
);

    adc_sample_t sample_dly;
    logic        threshold_hit;
    logic        word_write;
    logic        first_sample;
    logic        word_valid;
    fifo_word_t  word_data;

    adc_delay_line u_delay_line (
        .ADC_ENC        (ADC_ENC),
        .rst_adc_sync   (rst_adc_sync),
        .adc_in         (adc_in),
        .cfg_sample_dly (cfg_sample_dly),
        .sample_dly     (sample_dly)
    );

    adc_threshold_trigger u_threshold_trigger (
        .ADC_ENC            (ADC_ENC),
        .rst_adc_sync       (rst_adc_sync),
        .sample_dly         (sample_dly),
        .cfg_trig_mode      (cfg_trig_mode),
        .cfg_trig_threshold (cfg_trig_threshold),
        .threshold_hit      (threshold_hit)
    );

    adc_record_control u_record_control (
        .ADC_ENC             (ADC_ENC),
        .rst_adc_sync        (rst_adc_sync),
        .start               (start),
        .adc_sync            (adc_sync),
        .adc_trigger         (adc_trigger),
        .threshold_hit       (threshold_hit),
        .cfg_start_with_sync (cfg_start_with_sync),
        .cfg_ext_trigger_en  (cfg_ext_trigger_en),
        .cfg_single_data     (cfg_single_data),
        .cfg_data_cnt        (cfg_data_cnt),
        .word_write          (word_write),
        .first_sample        (first_sample),
        .done                (done)
    );

    adc_word_packer #(
        .ADC_ID    (ADC_ID),
        .HEADER_ID (HEADER_ID)
    ) u_word_packer (
        .ADC_ENC            (ADC_ENC),
        .rst_adc_sync       (rst_adc_sync),
        .sample_dly         (sample_dly),
        .adc_sync           (adc_sync),
        .word_write         (word_write),
        .first_sample       (first_sample),
        .cfg_single_data    (cfg_single_data),
        .cfg_ext_trigger_en (cfg_ext_trigger_en),
        .cfg_trig_mode      (cfg_trig_mode),
        .word_valid         (word_valid),
        .word_data          (word_data)
    );

    adc_sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_sample_fifo (
        .ADC_ENC      (ADC_ENC),
        .rst_adc_sync (rst_adc_sync),
        .word_valid   (word_valid),
        .word_data    (word_data),
        .fifo_read    (fifo_read),
        .fifo_data    (fifo_data),
        .fifo_empty   (fifo_empty),
        .lost_count   (lost_count),
        .lost_error   (lost_error)
    );

endmodule

/* logic/adc_sample_fifo.sv */
// show-ahead word fifo that drops and counts writes while full
`timescale 1ns/1ns

module adc_sample_fifo import adc_rx_pkg::*; #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic        ADC_ENC,
    input  logic        rst_adc_sync,
    input  logic        word_valid,
    input  fifo_word_t  word_data,
    input  logic        fifo_read,
    output fifo_word_t  fifo_data,
    output logic        fifo_empty,
    output lost_count_t lost_count,
    output logic        lost_error
);

    localparam int AW = $clog2(FIFO_DEPTH);

    fifo_word_t    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          push;
    logic          pop;

    assign full       = (count == (AW + 1)'(FIFO_DEPTH));
    assign fifo_empty = (count == '0);
    assign push       = word_valid && !full;
    assign pop        = fifo_read && !fifo_empty;

    always_ff @(posedge ADC_ENC) begin
        if (push) begin
            mem[wr_ptr] <= word_data;
        end
    end

    assign fifo_data = mem[rd_ptr]; // head of queue, valid while not empty

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            lost_count <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            if (word_valid && full && lost_count != 8'hff) begin
                lost_count <= lost_count + 8'd1; // saturates at 255
            end
        end
    end

    assign lost_error = (lost_count != '0);

endmodule

/* logic/adc_threshold_trigger.sv */
// threshold comparator on the delayed sample for below, above and drop modes
`timescale 1ns/1ns

module adc_threshold_trigger import adc_rx_pkg::*; (
    input  logic        ADC_ENC,
    input  logic        rst_adc_sync,
    input  adc_sample_t sample_dly,
    input  trig_mode_t  cfg_trig_mode,
    input  adc_sample_t cfg_trig_threshold,
    output logic        threshold_hit
);

    adc_sample_t prev_dly;
    adc_sample_t fall;

    // previous sample for the drop test
    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            prev_dly <= '0;
        end else begin
            prev_dly <= sample_dly;
        end
    end

    assign fall = prev_dly - sample_dly; // unsigned, wraps on a rise

    always_comb begin
        case (cfg_trig_mode)
            trig_below: threshold_hit = (sample_dly < cfg_trig_threshold);
            trig_above: threshold_hit = (sample_dly > cfg_trig_threshold);
            trig_drop:  threshold_hit = (fall > cfg_trig_threshold);
            default:    threshold_hit = 1'b0;
        endcase
    end

endmodule

/* logic/adc_word_packer.sv */
// packs delayed samples into 32-bit fifo words, one or two samples per word
`timescale 1ns/1ns

module adc_word_packer import adc_rx_pkg::*; #(
    parameter logic [1:0] ADC_ID    = 2'd0,
    parameter logic [0:0] HEADER_ID = 1'b0
) (
    input  logic        ADC_ENC,
    input  logic        rst_adc_sync,
    input  adc_sample_t sample_dly,
    input  logic        adc_sync,
    input  logic        word_write,
    input  logic        first_sample,
    input  logic        cfg_single_data,
    input  logic        cfg_ext_trigger_en,
    input  trig_mode_t  cfg_trig_mode,
    output logic        word_valid,
    output fifo_word_t  word_data
);

    adc_sample_t prev_sample;
    logic        prev_sync;
    logic        trig_flag_sel;
    logic        flag;
    fifo_word_t  word_next;

    always_ff @(posedge ADC_ENC) begin
        prev_sample <= sample_dly;
        prev_sync   <= adc_sync;
    end

    // with any trigger source on, the flag marks the record start instead of sync
    assign trig_flag_sel = cfg_ext_trigger_en || (cfg_trig_mode != trig_off);

    always_comb begin
        if (cfg_single_data) begin
            flag      = trig_flag_sel ? first_sample : adc_sync;
            word_next = {HEADER_ID, ADC_ID, flag, 14'd0, sample_dly};
        end else begin
            flag      = prev_sync; // sync of the older sample
            word_next = {HEADER_ID, ADC_ID, flag, prev_sample, sample_dly};
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= word_write;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (word_write) begin
            word_data <= word_next;
        end
    end

endmodule

/* record_control/adc_record_control.sv */
// record FSM: arming on sync, start and trigger events, sample counting, word write timing
`timescale 1ns/1ns

module adc_record_control import adc_rx_pkg::*; (
    input  logic       ADC_ENC,
    input  logic       rst_adc_sync,
    input  logic       start,
    input  logic       adc_sync,
    input  logic       adc_trigger,
    input  logic       threshold_hit,
    input  logic       cfg_start_with_sync,
    input  logic       cfg_ext_trigger_en,
    input  logic       cfg_single_data,
    input  rec_count_t cfg_data_cnt,
    output logic       word_write,
    output logic       first_sample,
    output logic       done
);

    typedef enum logic [1:0] {
        idle,
        wait_sync,
        recording
    } rec_state_t;

    rec_state_t state;
    rec_count_t rec_cnt;
    logic       sync_q;
    logic       sync_rise;
    logic       trig_evt;
    logic       start_evt;
    logic       phase;    // double mode: high on the second sample of a pair
    logic       last;

    assign sync_rise = adc_sync && !sync_q;
    assign trig_evt  = (cfg_ext_trigger_en && adc_trigger) || threshold_hit;

    always_comb begin
        case (state)
            idle:      start_evt = (start && !cfg_start_with_sync) || trig_evt;
            wait_sync: start_evt = sync_rise || trig_evt;
            default:   start_evt = 1'b0; // busy
        endcase
    end

    // zero length means record forever
    assign last = (cfg_data_cnt != '0) && (rec_cnt == cfg_data_cnt - 24'd1);

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            state   <= idle;
            rec_cnt <= '0;
            phase   <= 1'b0;
            sync_q  <= 1'b0;
        end else begin
            sync_q <= adc_sync;
            if (start_evt) begin
                state   <= recording;
                rec_cnt <= '0;
                phase   <= 1'b0;
            end else if (state == idle && start && cfg_start_with_sync) begin
                state <= wait_sync; // arm for next sync edge
            end else if (state == recording) begin
                phase <= !phase;
                if (last) begin
                    state <= idle;
                end
                if (rec_cnt != 24'hff_ffff) begin
                    rec_cnt <= rec_cnt + 24'd1;
                end
            end
        end
    end

    assign word_write   = (state == recording) && (cfg_single_data || phase);
    assign first_sample = (state == recording) && (rec_cnt == '0);
    assign done         = (state == idle);

endmodule
